// ==== rp_lab.f ====
hw/rp_pkg.sv
hw/sys_bus_decoder.sv
hw/housekeeping.sv
hw/adc_frontend.sv
hw/dac_backend.sv
hw/pwm_dac.sv
hw/rp_top.sv
test/rp_top_chk.sv
test/tb_rp_top.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := tb_rp_top
FLIST     := rp_lab.f
RUN_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) $(RUN_ARGS) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_rp_top.sv ====
// testbench for rp_top, table of bus accesses, pin checks,
// ADC codes (fixed and random), DAC levels, loopback, PWM duty counts

module tb_rp_top import rp_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned PWM_CH  = 4;
  localparam int unsigned PWM_W   = 8;
  localparam int          TIMEOUT = 20;  // cycles to wait for ack
  localparam int          N_RAND  = 6;   // random ADC code pairs

  typedef enum int {K_RD, K_WR, K_PIN, K_ADC, K_DAC, K_PWM} kind_e;

  // region base addresses
  localparam logic [31:0] A_HK  = 32'h0000_0000;
  localparam logic [31:0] A_ADC = 32'h0010_0000;
  localparam logic [31:0] A_DAC = 32'h0020_0000;
  localparam logic [31:0] A_PWM = 32'h0040_0000;
  localparam logic [31:0] A_UNU = 32'h0060_0000;  // region 6 has no slave

  logic                 adc_clk;
  logic                 rst_n_i;
  logic                 wb_cyc_i, wb_stb_i, wb_we_i;
  logic [WB_AW-1:0]     wb_adr_i;
  logic [WB_DW-1:0]     wb_dat_i, wb_dat_o;
  logic                 wb_ack_o;
  logic [ADC_RAW_W-1:0] adc_dat_a_i, adc_dat_b_i;
  logic [SIG_W-1:0]     dac_dat_a_o, dac_dat_b_o;
  logic [PWM_CH-1:0]    pwm_o;
  logic [7:0]           led_o;

  // test table with one entry per index
  string       t_name[$];
  kind_e       t_kind[$];
  logic [31:0] t_adr[$];   // bus address or pin select for K_PIN
  logic [31:0] t_stim[$];
  logic [31:0] t_exp[$];
  int          errors = 0;
  int          passed = 0;

  rp_top #(.PWM_CH(PWM_CH), .PWM_W(PWM_W)) rp_top_inst (.*);

  bind rp_top rp_top_chk #(.PWM_CH(PWM_CH)) rp_top_chk_inst (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .cyc_i   (wb_cyc_i), .stb_i (wb_stb_i), .ack_i (wb_ack_o),
    .led_i   (led_o), .pwm_i (pwm_o)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #50 adc_clk = ~adc_clk;  // 100 ns period
  end

  //////////////////////
  // helpers
  //////////////////////

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
    begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // request held until ack, dropped after the edge that samples it
  task automatic bus_cycle(input string name, input logic we, input logic [31:0] adr,
                           input logic [31:0] wdat, output logic [31:0] rdat);
    int n;
    n    = 0;
    rdat = 'x;
    @(posedge adc_clk);
    #10;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    do
    begin
      @(posedge adc_clk);
      #10;
      n++;
    end
    while (!wb_ack_o && n < TIMEOUT);
    if (!wb_ack_o)
    begin
      $display("%s: no ack from the bus within %0d cycles", name, TIMEOUT);
      errors++;
    end
    else
    begin
      rdat = wb_dat_o;  // valid while ack is high
      if (n != 1)
      begin
        $display("%s: ack came after %0d cycles instead of 1", name, n);
        errors++;
      end
    end
    @(posedge adc_clk);
    #10;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input string name, input logic [31:0] adr, input logic [31:0] dat);
    logic [31:0] unused_rd;
    bus_cycle(name, 1'b1, adr, dat, unused_rd);
  endtask

  task automatic wb_read(input string name, input logic [31:0] adr, output logic [31:0] dat);
    bus_cycle(name, 1'b0, adr, 32'h0, dat);
  endtask

  // keeps the sign bit and inverts bits 14..2 before sign extension
  function automatic logic [31:0] adc_readback(input logic [15:0] raw);
    logic [13:0] s;
    s            = {raw[15], ~raw[14:2]};
    adc_readback = {{18{s[13]}}, s};
  endfunction

  function automatic logic [31:0] pin_value(input logic [31:0] sel);
    case (sel)
      0:       pin_value = 32'(led_o);
      1:       pin_value = 32'(dac_dat_a_o);
      default: pin_value = 32'(dac_dat_b_o);
    endcase
  endfunction

  task automatic add_test(input string name, input kind_e kind, input logic [31:0] adr,
                          input logic [31:0] stim, input logic [31:0] exp);
    t_name.push_back(name);
    t_kind.push_back(kind);
    t_adr.push_back(adr);
    t_stim.push_back(stim);
    t_exp.push_back(exp);
  endtask

  //////////////////////
  // table
  //////////////////////

  task automatic build_table();
    logic [31:0] r;
    add_test("id_after_rst",  K_RD,  A_HK,      0, 32'h5250_0001);
    add_test("dac_a_rst",     K_PIN, 1,         0, 32'h0000_1FFF);  // code of 0
    add_test("dac_b_rst",     K_PIN, 2,         0, 32'h0000_1FFF);
    add_test("led_rst",       K_PIN, 0,         0, 32'h0);
    add_test("led_write",     K_WR,  A_HK + 8,  32'h0000_00A5, 0);
    add_test("led_read",      K_RD,  A_HK + 8,  0, 32'h0000_00A5);
    add_test("led_pin",       K_PIN, 0,         0, 32'h0000_00A5);
    add_test("id_write",      K_WR,  A_HK,      32'hFFFF_FFFF, 0);  // read-only
    add_test("id_kept",       K_RD,  A_HK,      0, 32'h5250_0001);
    add_test("loop_set",      K_WR,  A_HK + 4,  1, 0);
    add_test("loop_read",     K_RD,  A_HK + 4,  0, 32'h1);
    add_test("loop_clear",    K_WR,  A_HK + 4,  0, 0);
    // ADC stim is {raw b, raw a}
    add_test("adc_a_zero",    K_ADC, A_ADC,     32'hFFFF_0000, 32'h0000_1FFF);
    add_test("adc_b_full",    K_ADC, A_ADC + 4, 32'hFFFF_0000, 32'hFFFF_E000);
    add_test("adc_a_8000",    K_ADC, A_ADC,     32'h7FFC_8000, 32'hFFFF_FFFF);
    add_test("adc_b_7ffc",    K_ADC, A_ADC + 4, 32'h7FFC_8000, 32'h0000_0000);
    add_test("adc_a_4000",    K_ADC, A_ADC,     32'h0000_4000, 32'h0000_0FFF);
    for (int k = 0; k < N_RAND; k++)
    begin
      r = $urandom;
      add_test($sformatf("adc_rand%0d_a", k), K_ADC, A_ADC,     r, adc_readback(r[15:0]));
      add_test($sformatf("adc_rand%0d_b", k), K_ADC, A_ADC + 4, r, adc_readback(r[31:16]));
    end
    // DAC stim is {ofs, gen}, expected is the 14 bit DAC code
    add_test("dac_a_small",   K_DAC, A_DAC,     32'hFFE2_0064, 32'h0000_1FB9);  // 70
    add_test("dac_a_pos_sat", K_DAC, A_DAC,     32'h03E8_1F40, 32'h0000_0000);
    add_test("dac_a_minus1",  K_DAC, A_DAC,     32'h0000_FFFF, 32'h0000_2000);
    add_test("dac_a_neg_sat", K_DAC, A_DAC,     32'hFC18_E0C0, 32'h0000_3FFF);
    add_test("dac_b_pos_sat", K_DAC, A_DAC + 4, 32'h0FA0_1388, 32'h0000_0000);
    add_test("gen_a_read",    K_RD,  A_DAC,     0, 32'hFFFF_E0C0);  // -8000
    add_test("loop_enable",   K_WR,  A_HK + 4,  1, 0);
    add_test("loop_a",        K_RD,  A_ADC,     0, 32'hFFFF_E000);  // -8192
    add_test("loop_b",        K_RD,  A_ADC + 4, 0, 32'h0000_1FFF);  // 8191
    add_test("loop_disable",  K_WR,  A_HK + 4,  0, 0);
    // PWM stim is the duty, expected the high count per period
    add_test("pwm0_duty0",    K_PWM, A_PWM,      0,   0);
    add_test("pwm1_duty64",   K_PWM, A_PWM + 4,  64,  64);
    add_test("pwm2_duty255",  K_PWM, A_PWM + 8,  255, 255);
    add_test("pwm3_duty1",    K_PWM, A_PWM + 12, 1,   1);
    add_test("pwm1_read",     K_RD,  A_PWM + 4,  0,   64);
    add_test("region6_read",  K_RD,  A_UNU,      0,   0);
    add_test("region3_write", K_WR,  32'h0030_0000, 32'h0000_1234, 0);
  endtask

  task automatic run_test(input int i);
    logic [31:0] rd;
    int          ch;
    int          hi;
    case (t_kind[i])
      K_RD:
      begin
        wb_read(t_name[i], t_adr[i], rd);
        check(t_name[i], t_exp[i], rd);
      end
      K_WR:  wb_write(t_name[i], t_adr[i], t_stim[i]);
      K_PIN: check(t_name[i], t_exp[i], pin_value(t_adr[i]));
      K_ADC:
      begin
        adc_dat_a_i = t_stim[i][15:0];
        adc_dat_b_i = t_stim[i][31:16];
        wb_read(t_name[i], t_adr[i], rd);  // input register then readback
        check(t_name[i], t_exp[i], rd);
      end
      K_DAC:
      begin
        wb_write(t_name[i], t_adr[i], {16'h0, t_stim[i][15:0]});      // gen
        wb_write(t_name[i], t_adr[i] + 8, {16'h0, t_stim[i][31:16]}); // ofs
        repeat (2) @(posedge adc_clk);
        #10;
        check(t_name[i], t_exp[i], t_adr[i][2] ? 32'(dac_dat_b_o) : 32'(dac_dat_a_o));
      end
      K_PWM:
      begin
        ch = int'(t_adr[i][REG_LSB +: REG_BITS]);
        hi = 0;
        wb_write(t_name[i], t_adr[i], t_stim[i]);
        repeat (2) @(posedge adc_clk);  // compare register catches up
        for (int c = 0; c < (1 << PWM_W); c++)
        begin
          @(posedge adc_clk);
          #10;
          if (pwm_o[ch])
            hi++;
        end
        check(t_name[i], t_exp[i], 32'(hi));
      end
      default: ;
    endcase
  endtask

  //////////////////////
  // main sequence
  //////////////////////

  initial
  begin
    int err0;
    void'($urandom(32'head3_400e));  // seed once
    rst_n_i     = 1'b0;
    wb_cyc_i    = 1'b0;
    wb_stb_i    = 1'b0;
    wb_we_i     = 1'b0;
    wb_adr_i    = '0;
    wb_dat_i    = '0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    build_table();
    repeat (16) @(posedge adc_clk);
    #10;
    rst_n_i = 1'b1;
    for (int i = 0; i < t_name.size(); i++)
    begin
      err0 = errors;
      run_test(i);
      if (errors == err0)
        passed++;
      $display("%-16s %s", t_name[i], (errors == err0) ? "passed" : "failed");
    end
    if (rp_top_inst.rp_top_chk_inst.fails != 0)
      $display("%0d assertion failures during the run", rp_top_inst.rp_top_chk_inst.fails);
    errors += rp_top_inst.rp_top_chk_inst.fails;
    $display("%0d tests, %0d passed, %0d errors", t_name.size(), passed, errors);
    if (errors == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== test/rp_top_chk.sv ====
// concurrent checks on the system bus handshake
// and on the outputs held in reset

module rp_top_chk #(
  parameter int unsigned PWM_CH = 4
)(
  input logic              adc_clk,
  input logic              rst_n_i,
  input logic              cyc_i,
  input logic              stb_i,
  input logic              ack_i,
  input logic [7:0]        led_i,
  input logic [PWM_CH-1:0] pwm_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int fails = 0;  // failed assertion count

  // ack only inside a request
  ack_in_req: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |-> (cyc_i && stb_i))
  else
  begin
    fails++;
    $error("ack without cyc and stb");
  end

  ack_single: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    ack_i |=> !ack_i)  // one cycle pulse
  else
  begin
    fails++;
    $error("ack high for two cycles");
  end

  // outputs clear one edge into the synchronous reset
  rst_outputs: assert property (@(posedge adc_clk)
    !rst_n_i |=> (led_i == '0 && pwm_i == '0))
  else
  begin
    fails++;
    $error("led or pwm outputs not zero in reset");
  end

endmodule

// ==== hw/rp_top.sv ====
// top level of the signal core
// bus decoder, housekeeping, ADC front end, DAC back end, PWM outputs

module rp_top import rp_pkg::*; #(
  parameter int unsigned PWM_CH = 4,
  parameter int unsigned PWM_W  = 8
)(
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  // wishbone slave
  input  logic                 wb_cyc_i,
  input  logic                 wb_stb_i,
  input  logic                 wb_we_i,
  input  logic [WB_AW-1:0]     wb_adr_i,
  input  logic [WB_DW-1:0]     wb_dat_i,
  output logic [WB_DW-1:0]     wb_dat_o,
  output logic                 wb_ack_o,
  // converters
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  output logic [SIG_W-1:0]     dac_dat_a_o,
  output logic [SIG_W-1:0]     dac_dat_b_o,
  output logic [PWM_CH-1:0]    pwm_o,
  output logic [7:0]           led_o
);

  wire [N_REGIONS-1:0]            slv_stb;
  wire                            slv_we;
  wire [REG_BITS-1:0]             slv_adr;
  wire [WB_DW-1:0]                slv_wdat;
  wire [N_REGIONS-1:0][WB_DW-1:0] slv_rdat;
  wire [N_REGIONS-1:0]            slv_ack;

  sample_t loop_a, loop_b;  // saturated DAC samples
  logic    digital_loop;

  //////////////////////
  // bus decoder
  //////////////////////

  sys_bus_decoder sys_bus_decoder_inst (
    .adc_clk   (adc_clk),  .rst_n_i   (rst_n_i),
    .wb_cyc_i  (wb_cyc_i), .wb_stb_i  (wb_stb_i), .wb_we_i (wb_we_i),
    .wb_adr_i  (wb_adr_i), .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o), .wb_ack_o  (wb_ack_o),
    .slv_stb_o (slv_stb),  .slv_we_o  (slv_we),   .slv_adr_o (slv_adr),
    .slv_dat_o (slv_wdat), .slv_dat_i (slv_rdat), .slv_ack_i (slv_ack)
  );

  // the decoder answers the empty regions itself
  for (genvar r = 0; r < N_REGIONS; r++)
  begin : g_unused
    if (r != REG_HK && r != REG_ADC && r != REG_DAC && r != REG_PWM)
    begin : g_tie
      assign slv_rdat[r] = '0;
      assign slv_ack[r]  = 1'b0;
    end
  end

  //////////////////////
  // slaves
  //////////////////////

  housekeeping housekeeping_inst (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .stb_i   (slv_stb[REG_HK]), .we_i (slv_we), .adr_i (slv_adr), .dat_i (slv_wdat),
    .dat_o   (slv_rdat[REG_HK]), .ack_o (slv_ack[REG_HK]),
    .digital_loop_o (digital_loop), .led_o (led_o)
  );

  adc_frontend adc_frontend_inst (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .adc_dat_a_i (adc_dat_a_i), .adc_dat_b_i (adc_dat_b_i),
    .digital_loop_i (digital_loop), .loop_a_i (loop_a), .loop_b_i (loop_b),
    .stb_i   (slv_stb[REG_ADC]), .we_i (slv_we), .adr_i (slv_adr),
    .dat_o   (slv_rdat[REG_ADC]), .ack_o (slv_ack[REG_ADC])
  );

  dac_backend dac_backend_inst (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .stb_i   (slv_stb[REG_DAC]), .we_i (slv_we), .adr_i (slv_adr), .dat_i (slv_wdat),
    .dat_o   (slv_rdat[REG_DAC]), .ack_o (slv_ack[REG_DAC]),
    .loop_a_o (loop_a), .loop_b_o (loop_b),
    .dac_dat_a_o (dac_dat_a_o), .dac_dat_b_o (dac_dat_b_o)
  );

  pwm_dac #(
    .PWM_CH (PWM_CH),
    .PWM_W  (PWM_W)
  ) pwm_dac_inst (
    .adc_clk (adc_clk), .rst_n_i (rst_n_i),
    .stb_i   (slv_stb[REG_PWM]), .we_i (slv_we), .adr_i (slv_adr), .dat_i (slv_wdat),
    .dat_o   (slv_rdat[REG_PWM]), .ack_o (slv_ack[REG_PWM]),
    .pwm_o   (pwm_o)
  );

endmodule

// ==== hw/pwm_dac.sv ====
// PWM analog outputs
// duty registers, shared free-running counter, per channel compare

module pwm_dac import rp_pkg::*; #(
  parameter int unsigned PWM_CH = 4,  // at most 2**REG_BITS channels
  parameter int unsigned PWM_W  = 8   // duty and counter width
)(
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [REG_BITS-1:0] adr_i,
  input  logic [WB_DW-1:0]    dat_i,
  output logic [WB_DW-1:0]    dat_o,
  output logic                ack_o,
  output logic [PWM_CH-1:0]   pwm_o
);

  logic [PWM_CH-1:0][PWM_W-1:0] duty;
  logic [PWM_W-1:0]             cnt;  // wraps every 2**PWM_W cycles
  logic                         acc;
  logic                         hit;  // offset names a channel

  assign acc = stb_i & ~ack_o;
  assign hit = (adr_i < PWM_CH);

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_o <= 1'b0;
      duty  <= '0;
    end
    else
    begin
      ack_o <= acc;
      if (acc && we_i && hit)
        duty[adr_i] <= dat_i[PWM_W-1:0];
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (acc)
      dat_o <= hit ? WB_DW'(duty[adr_i]) : '0;
  end

  //////////////////////
  // pulse generation
  //////////////////////

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      cnt   <= '0;
      pwm_o <= '0;
    end
    else
    begin
      cnt <= cnt + 1'b1;
      for (int n = 0; n < PWM_CH; n++)
        pwm_o[n] <= (cnt < duty[n]);  // duty high cycles per period
    end
  end

endmodule

// ==== hw/dac_backend.sv ====
// DAC back end
// level registers, per channel sum with saturation,
// conversion to negative slope DAC code and output registers

module dac_backend import rp_pkg::*; (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [REG_BITS-1:0] adr_i,
  input  logic [WB_DW-1:0]    dat_i,
  output logic [WB_DW-1:0]    dat_o,
  output logic                ack_o,
  output sample_t             loop_a_o,
  output sample_t             loop_b_o,
  output logic [SIG_W-1:0]    dac_dat_a_o,
  output logic [SIG_W-1:0]    dac_dat_b_o
);

  sample_t                gen_a, gen_b, ofs_a, ofs_b;  // level registers
  logic signed [SIG_W:0]  sum_a, sum_b;                // one guard bit
  logic                   acc;

  // clamp to the 14 bit range when the top two bits differ
  function automatic sample_t sat(input logic signed [SIG_W:0] s);
    if (s[SIG_W] ^ s[SIG_W-1])
      sat = {s[SIG_W], {(SIG_W-1){~s[SIG_W]}}};
    else
      sat = s[SIG_W-1:0];
  endfunction

  // sign kept, magnitude bits inverted
  function automatic logic [SIG_W-1:0] dac_code(input sample_t s);
    dac_code = {s[SIG_W-1], ~s[SIG_W-2:0]};
  endfunction

  assign acc = stb_i & ~ack_o;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_o <= 1'b0;
      gen_a <= '0;
      gen_b <= '0;
      ofs_a <= '0;
      ofs_b <= '0;
    end
    else
    begin
      ack_o <= acc;
      if (acc && we_i)
      begin
        case (adr_i)
          0:       gen_a <= dat_i[SIG_W-1:0];
          1:       gen_b <= dat_i[SIG_W-1:0];
          2:       ofs_a <= dat_i[SIG_W-1:0];
          3:       ofs_b <= dat_i[SIG_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge adc_clk)
  begin
    if (acc)
    begin
      case (adr_i)
        0:       dat_o <= {{(WB_DW-SIG_W){gen_a[SIG_W-1]}}, gen_a};
        1:       dat_o <= {{(WB_DW-SIG_W){gen_b[SIG_W-1]}}, gen_b};
        2:       dat_o <= {{(WB_DW-SIG_W){ofs_a[SIG_W-1]}}, ofs_a};
        3:       dat_o <= {{(WB_DW-SIG_W){ofs_b[SIG_W-1]}}, ofs_b};
        default: dat_o <= '0;
      endcase
    end
  end

  //////////////////////
  // summing and output
  //////////////////////

  assign sum_a = gen_a + ofs_a;  // sign extended to 15 bits
  assign sum_b = gen_b + ofs_b;

  assign loop_a_o = sat(sum_a);
  assign loop_b_o = sat(sum_b);

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      dac_dat_a_o <= dac_code('0);  // mid scale code 14'h1FFF
      dac_dat_b_o <= dac_code('0);
    end
    else
    begin
      dac_dat_a_o <= dac_code(loop_a_o);
      dac_dat_b_o <= dac_code(loop_b_o);
    end
  end

endmodule

// ==== hw/adc_frontend.sv ====
// ADC front end
// input registers, negative slope code to two's complement,
// loopback select and sample readback registers

module adc_frontend import rp_pkg::*; (
  input  logic                 adc_clk,
  input  logic                 rst_n_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_a_i,
  input  logic [ADC_RAW_W-1:0] adc_dat_b_i,
  input  logic                 digital_loop_i,
  input  sample_t              loop_a_i,
  input  sample_t              loop_b_i,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  logic [REG_BITS-1:0]  adr_i,
  output logic [WB_DW-1:0]     dat_o,
  output logic                 ack_o
);

  logic [ADC_RAW_W-1:0] raw_a, raw_b;  // input registers
  sample_t              smp_a, smp_b;
  logic                 acc;

  always_ff @(posedge adc_clk)
  begin
    raw_a <= adc_dat_a_i;
    raw_b <= adc_dat_b_i;
  end

  // top 14 bits, sign kept, rest inverted; low 2 bits dropped
  assign smp_a = digital_loop_i ? loop_a_i
                                : {raw_a[ADC_RAW_W-1], ~raw_a[ADC_RAW_W-2 -: SIG_W-1]};
  assign smp_b = digital_loop_i ? loop_b_i
                                : {raw_b[ADC_RAW_W-1], ~raw_b[ADC_RAW_W-2 -: SIG_W-1]};

  //////////////////////
  // bus side
  //////////////////////

  assign acc = stb_i & ~ack_o;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      ack_o <= 1'b0;
    else
      ack_o <= acc;
  end

  // nothing here is writable
  always_ff @(posedge adc_clk)
  begin
    if (acc)
    begin
      if (we_i)
        dat_o <= '0;
      else if (adr_i == 0)
        dat_o <= {{(WB_DW-SIG_W){smp_a[SIG_W-1]}}, smp_a};  // sign extended
      else if (adr_i == 1)
        dat_o <= {{(WB_DW-SIG_W){smp_b[SIG_W-1]}}, smp_b};
      else
        dat_o <= '0;
    end
  end

endmodule

// ==== hw/housekeeping.sv ====
// housekeeping registers
// identification, digital loopback enable, LED byte

module housekeeping import rp_pkg::*; (
  input  logic                adc_clk,
  input  logic                rst_n_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  logic [REG_BITS-1:0] adr_i,
  input  logic [WB_DW-1:0]    dat_i,
  output logic [WB_DW-1:0]    dat_o,
  output logic                ack_o,
  output logic                digital_loop_o,
  output logic [7:0]          led_o
);

  logic acc;  // first cycle of an access

  assign acc = stb_i & ~ack_o;

  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
    begin
      ack_o          <= 1'b0;
      digital_loop_o <= 1'b0;
      led_o          <= '0;
    end
    else
    begin
      ack_o <= acc;
      if (acc && we_i)
      begin
        case (adr_i)
          1:       digital_loop_o <= dat_i[0];
          2:       led_o          <= dat_i[7:0];
          default: ;  // ID is read-only
        endcase
      end
    end
  end

  // read data valid with ack
  always_ff @(posedge adc_clk)
  begin
    if (acc)
    begin
      case (adr_i)
        0:       dat_o <= RP_ID;
        1:       dat_o <= {{(WB_DW-1){1'b0}}, digital_loop_o};
        2:       dat_o <= {{(WB_DW-8){1'b0}}, led_o};
        default: dat_o <= '0;
      endcase
    end
  end

endmodule

// ==== hw/sys_bus_decoder.sv ====
// wishbone region decoder
// strobe fan-out, read data and ack mux, responder for unused regions

module sys_bus_decoder import rp_pkg::*; (
  input  logic                                adc_clk,
  input  logic                                rst_n_i,
  input  logic                                wb_cyc_i,
  input  logic                                wb_stb_i,
  input  logic                                wb_we_i,
  input  logic [WB_AW-1:0]                    wb_adr_i,
  input  logic [WB_DW-1:0]                    wb_dat_i,
  output logic [WB_DW-1:0]                    wb_dat_o,
  output logic                                wb_ack_o,
  output logic [N_REGIONS-1:0]                slv_stb_o,  // one strobe per region
  output logic                                slv_we_o,
  output logic [REG_BITS-1:0]                 slv_adr_o,
  output logic [WB_DW-1:0]                    slv_dat_o,
  input  logic [N_REGIONS-1:0][WB_DW-1:0]     slv_dat_i,
  input  logic [N_REGIONS-1:0]                slv_ack_i
);

  localparam int unsigned REGION_W = $clog2(N_REGIONS);
  // regions with a real slave behind them
  localparam logic [N_REGIONS-1:0] USED = N_REGIONS'((1 << REG_HK) | (1 << REG_ADC) |
                                                     (1 << REG_DAC) | (1 << REG_PWM));

  logic [REGION_W-1:0] region;
  logic                req;         // cyc and stb together
  logic                unused_ack;  // own ack for empty regions

  assign region = wb_adr_i[REGION_LSB +: REGION_W];
  assign req    = wb_cyc_i & wb_stb_i;

  // strobe goes only to the addressed region
  always_comb
  begin
    slv_stb_o         = '0;
    slv_stb_o[region] = req;
  end

  assign slv_we_o  = wb_we_i;
  assign slv_adr_o = wb_adr_i[REG_LSB +: REG_BITS];
  assign slv_dat_o = wb_dat_i;

  // empty regions answer after one cycle, like a slave
  always_ff @(posedge adc_clk)
  begin
    if (!rst_n_i)
      unused_ack <= 1'b0;
    else
      unused_ack <= req & ~USED[region] & ~unused_ack;
  end

  assign wb_dat_o = slv_dat_i[region];  // empty regions are tied to 0
  assign wb_ack_o = slv_ack_i[region] | unused_ack;

endmodule

// ==== hw/rp_pkg.sv ====
// shared widths, address map and sample type
// region numbers of the system bus slaves

package rp_pkg;

  //////////////////////
  // wishbone bus
  //////////////////////

  localparam int unsigned WB_AW      = 32;  // address width
  localparam int unsigned WB_DW      = 32;  // data width
  localparam int unsigned N_REGIONS  = 8;   // decoded regions
  localparam int unsigned REGION_LSB = 20;  // start of the 3 bit region field
  localparam int unsigned REG_LSB    = 2;   // word offset inside a region
  localparam int unsigned REG_BITS   = 3;

  //////////////////////
  // signal path
  //////////////////////

  localparam int unsigned ADC_RAW_W = 16;  // raw converter bus
  localparam int unsigned SIG_W     = 14;  // usable sample bits

  typedef logic signed [SIG_W-1:0] sample_t;  // two's complement sample

  localparam logic [WB_DW-1:0] RP_ID = 32'h5250_0001;

  // region numbers
  localparam int unsigned REG_HK  = 0;
  localparam int unsigned REG_ADC = 1;
  localparam int unsigned REG_DAC = 2;
  localparam int unsigned REG_PWM = 4;

endpackage
